// File: hdl/offload_pkg.sv
/*
 * Offload hub shared definitions: request and response payloads,
 * target encoding and the configuration instruction fields.
 */

package offload_pkg;

  // ---------------------------------------------------------------------
  // Widths and counts
  // ---------------------------------------------------------------------
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned NumTargets = 3;

  // ---------------------------------------------------------------------
  // Offload channel payloads
  // ---------------------------------------------------------------------

  // One request from the core, 103 bits
  typedef struct packed {
    logic [4:0]           id;
    logic [1:0]           addr;
    logic [DataWidth-1:0] data_op;
    logic [DataWidth-1:0] data_arga;
    logic [DataWidth-1:0] data_argb;
  } acc_req_t;

  // One response to the core, 38 bits
  typedef struct packed {
    logic [4:0]           id;
    logic                 error;
    logic [DataWidth-1:0] data;
  } acc_rsp_t;

  // Target select carried in the request addr field.
  // Encoding 3 has no target behind it
  typedef enum logic [1:0] {
    TGT_FPU    = 2'd0,
    TGT_SHARED = 2'd1,
    TGT_SSR    = 2'd2
  } tgt_e;

  // ---------------------------------------------------------------------
  // Stream configuration instructions
  // ---------------------------------------------------------------------

  // 12-bit configuration address, register index above data mover index
  typedef struct packed {
    logic [6:0] reg_idx;
    logic [4:0] dm_idx;
  } cfg_addr_t;

  // Major opcode of all configuration instructions (custom-1 space)
  localparam logic [6:0] SsrCfgOpcode = 7'b0101011;

  // funct3 selects the form
  localparam logic [2:0] F3ScfgRi = 3'b001;
  localparam logic [2:0] F3ScfgWi = 3'b010;
  localparam logic [2:0] F3ScfgR  = 3'b101;
  localparam logic [2:0] F3ScfgW  = 3'b110;

endpackage

// File: hdl/ssr_cfg_unit.sv
/*
 * Stream configuration unit. Decodes the immediate and register forms of
 * the configuration instructions, reads and writes the configuration bank
 * and returns one buffered response per request.
 */

`timescale 1ns/1ns

module ssr_cfg_unit #(
  parameter int unsigned NumSsrs    = 2,
  parameter int unsigned NumCfgRegs = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  offload_pkg::acc_req_t req_i,
  input  logic                 qvalid_i,
  output logic                 qready_o,
  output offload_pkg::acc_rsp_t rsp_o,
  output logic                 pvalid_o,
  input  logic                 pready_i
);

  import offload_pkg::*;

  // Index widths into the bank, at least one bit each
  localparam int unsigned DmSelWidth  = (NumSsrs > 1) ? $clog2(NumSsrs) : 1;
  localparam int unsigned RegSelWidth = (NumCfgRegs > 1) ? $clog2(NumCfgRegs) : 1;

  // ---------------------------------------------------------------------
  // Instruction decode
  // ---------------------------------------------------------------------
  logic [2:0]             funct3;
  logic                   is_imm;
  logic                   is_write;
  cfg_addr_t              cfg_addr;
  logic                   in_range;
  logic [DmSelWidth-1:0]  dm_sel;
  logic [RegSelWidth-1:0] reg_sel;

  assign funct3 = req_i.data_op[14:12];

  always_comb begin
    is_imm   = (funct3 == F3ScfgRi) || (funct3 == F3ScfgWi);
    is_write = (funct3 == F3ScfgWi) || (funct3 == F3ScfgW);
    // Immediate forms carry the address in the I-type immediate
    if (is_imm) begin
      cfg_addr = cfg_addr_t'(req_i.data_op[31:20]);
    end else begin
      cfg_addr = cfg_addr_t'(req_i.data_argb[11:0]);
    end
  end

  assign in_range = (cfg_addr.dm_idx < NumSsrs) && (cfg_addr.reg_idx < NumCfgRegs);
  assign dm_sel   = cfg_addr.dm_idx[DmSelWidth-1:0];
  assign reg_sel  = cfg_addr.reg_idx[RegSelWidth-1:0];

  // ---------------------------------------------------------------------
  // Configuration bank
  // ---------------------------------------------------------------------
  logic [NumSsrs-1:0][NumCfgRegs-1:0][DataWidth-1:0] cfg_q;
  logic [DataWidth-1:0]                              rdata;

  // Old value of the addressed register, zero outside the bank
  assign rdata = in_range ? cfg_q[dm_sel][reg_sel] : '0;

  // ---------------------------------------------------------------------
  // Handshake and response buffer
  // ---------------------------------------------------------------------
  logic     accept;
  logic     pvalid_q;
  acc_rsp_t rsp_q;

  // Take a new request when the buffer is free or drains this cycle
  assign qready_o = !pvalid_q || pready_i;
  assign accept   = qvalid_i && qready_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      cfg_q <= '0;
    end else if (accept && is_write && in_range) begin
      cfg_q[dm_sel][reg_sel] <= req_i.data_arga;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      pvalid_q <= 1'b0;
    end else if (accept) begin
      pvalid_q <= 1'b1;
    end else if (pready_i) begin
      pvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      // Writes return id 0 so the core does no write-back
      rsp_q.id    <= is_write ? 5'd0 : req_i.id;
      rsp_q.error <= 1'b0;
      rsp_q.data  <= rdata;
    end
  end

  assign rsp_o    = rsp_q;
  assign pvalid_o = pvalid_q;

  // ---------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------

  // Only configuration instructions are routed here
  assert property (@(posedge clk_i) disable iff (rst_ni)
    accept |-> (req_i.data_op[6:0] == SsrCfgOpcode))
    else $error("ssr_cfg_unit: accepted request with foreign opcode");

  // Buffered response waits for the arbiter
  assert property (@(posedge clk_i) disable iff (rst_ni)
    (pvalid_o && !pready_i) |=> (pvalid_o && $stable(rsp_o)))
    else $error("ssr_cfg_unit: response dropped or changed under back-pressure");

endmodule

// File: hdl/offload_xbar.sv
/*
 * Offload crossbar. Steers core requests to one target by the addr field
 * and merges the target responses with a round-robin arbiter.
 */

`timescale 1ns/1ns

module offload_xbar (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  // Core side
  input  offload_pkg::acc_req_t                           acc_req_i,
  input  logic                                            acc_qvalid_i,
  output logic                                            acc_qready_o,
  output offload_pkg::acc_rsp_t                           acc_rsp_o,
  output logic                                            acc_pvalid_o,
  input  logic                                            acc_pready_i,
  // Target side, indexed by target number
  output logic                  [offload_pkg::NumTargets-1:0] tgt_qvalid_o,
  input  logic                  [offload_pkg::NumTargets-1:0] tgt_qready_i,
  input  offload_pkg::acc_rsp_t [offload_pkg::NumTargets-1:0] tgt_rsp_i,
  input  logic                  [offload_pkg::NumTargets-1:0] tgt_pvalid_i,
  output logic                  [offload_pkg::NumTargets-1:0] tgt_pready_o
);

  import offload_pkg::*;

  // ---------------------------------------------------------------------
  // Request steering
  // ---------------------------------------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < NumTargets; i++) begin
      tgt_qvalid_o[i] = acc_qvalid_i && (acc_req_i.addr == 2'(i));
    end
  end

  // Addr 3 has no target and is never ready
  assign acc_qready_o = (acc_req_i.addr < NumTargets) ? tgt_qready_i[acc_req_i.addr] : 1'b0;

  // ---------------------------------------------------------------------
  // Response arbitration
  // ---------------------------------------------------------------------
  tgt_e rr_q;
  tgt_e rr_gnt;
  tgt_e gnt_q;
  tgt_e gnt_sel;
  tgt_e rr_next;
  logic lock_q;
  logic rsp_hs;

  // First valid target at or after the pointer
  always_comb begin : rr_search
    int unsigned idx;
    logic        found;
    rr_gnt = rr_q;
    found  = 1'b0;
    for (int unsigned k = 0; k < NumTargets; k++) begin
      idx = (int'(rr_q) + k) % NumTargets;
      if (!found && tgt_pvalid_i[idx]) begin
        rr_gnt = tgt_e'(idx);
        found  = 1'b1;
      end
    end
  end

  // A stalled response keeps its grant until it is taken
  assign gnt_sel = lock_q ? gnt_q : rr_gnt;

  assign acc_pvalid_o = tgt_pvalid_i[gnt_sel];
  assign acc_rsp_o    = tgt_rsp_i[gnt_sel];
  assign rsp_hs       = acc_pvalid_o && acc_pready_i;

  always_comb begin
    for (int unsigned i = 0; i < NumTargets; i++) begin
      tgt_pready_o[i] = acc_pready_i && (gnt_sel == tgt_e'(i));
    end
  end

  // Pointer wraps from the last target back to the first
  assign rr_next = (gnt_sel == TGT_SSR) ? TGT_FPU : tgt_e'(gnt_sel + 2'd1);

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rr_q   <= TGT_FPU;
      lock_q <= 1'b0;
      gnt_q  <= TGT_FPU;
    end else begin
      if (rsp_hs) begin
        rr_q <= rr_next;
      end
      lock_q <= acc_pvalid_o && !acc_pready_i;
      gnt_q  <= gnt_sel;
    end
  end

  // ---------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------

  // The core only offloads to existing targets
  assert property (@(posedge clk_i) disable iff (rst_ni)
    acc_qvalid_i |-> (acc_req_i.addr != 2'd3))
    else $error("offload_xbar: request to unmapped target 3");

  // Grant and payload hold while the core stalls
  assert property (@(posedge clk_i) disable iff (rst_ni)
    (acc_pvalid_o && !acc_pready_i) |=> (acc_pvalid_o && $stable(acc_rsp_o)))
    else $error("offload_xbar: response unstable under back-pressure");

endmodule

// File: hdl/offload_hub.sv
/*
 * Offload hub top level. Connects the core offload channel to the FPU
 * and shared multiply/divide ports and to the stream configuration unit.
 */

`timescale 1ns/1ns

module offload_hub #(
  parameter int unsigned NumSsrs    = 2,
  parameter int unsigned NumCfgRegs = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Core offload channel
  input  offload_pkg::acc_req_t acc_req_i,
  input  logic                  acc_qvalid_i,
  output logic                  acc_qready_o,
  output offload_pkg::acc_rsp_t acc_rsp_o,
  output logic                  acc_pvalid_o,
  input  logic                  acc_pready_i,
  // FPU subsystem
  output logic                  fpu_qvalid_o,
  input  logic                  fpu_qready_i,
  input  offload_pkg::acc_rsp_t fpu_rsp_i,
  input  logic                  fpu_pvalid_i,
  output logic                  fpu_pready_o,
  // Shared multiply/divide unit
  output logic                  shared_qvalid_o,
  input  logic                  shared_qready_i,
  input  offload_pkg::acc_rsp_t shared_rsp_i,
  input  logic                  shared_pvalid_i,
  output logic                  shared_pready_o
);

  import offload_pkg::*;

  logic     [NumTargets-1:0] tgt_qvalid;
  logic     [NumTargets-1:0] tgt_qready;
  acc_rsp_t [NumTargets-1:0] tgt_rsp;
  logic     [NumTargets-1:0] tgt_pvalid;
  logic     [NumTargets-1:0] tgt_pready;

  // Configuration unit handshake
  logic     ssr_qvalid;
  logic     ssr_qready;
  acc_rsp_t ssr_rsp;
  logic     ssr_pvalid;
  logic     ssr_pready;

  // ---------------------------------------------------------------------
  // Target port mapping
  // ---------------------------------------------------------------------
  assign fpu_qvalid_o          = tgt_qvalid[TGT_FPU];
  assign shared_qvalid_o       = tgt_qvalid[TGT_SHARED];
  assign ssr_qvalid            = tgt_qvalid[TGT_SSR];
  assign tgt_qready[TGT_FPU]    = fpu_qready_i;
  assign tgt_qready[TGT_SHARED] = shared_qready_i;
  assign tgt_qready[TGT_SSR]    = ssr_qready;
  assign tgt_rsp[TGT_FPU]       = fpu_rsp_i;
  assign tgt_rsp[TGT_SHARED]    = shared_rsp_i;
  assign tgt_rsp[TGT_SSR]       = ssr_rsp;
  assign tgt_pvalid[TGT_FPU]    = fpu_pvalid_i;
  assign tgt_pvalid[TGT_SHARED] = shared_pvalid_i;
  assign tgt_pvalid[TGT_SSR]    = ssr_pvalid;
  assign fpu_pready_o          = tgt_pready[TGT_FPU];
  assign shared_pready_o       = tgt_pready[TGT_SHARED];
  assign ssr_pready            = tgt_pready[TGT_SSR];

  offload_xbar i_offload_xbar (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .acc_req_i    (acc_req_i),
    .acc_qvalid_i (acc_qvalid_i),
    .acc_qready_o (acc_qready_o),
    .acc_rsp_o    (acc_rsp_o),
    .acc_pvalid_o (acc_pvalid_o),
    .acc_pready_i (acc_pready_i),
    .tgt_qvalid_o (tgt_qvalid),
    .tgt_qready_i (tgt_qready),
    .tgt_rsp_i    (tgt_rsp),
    .tgt_pvalid_i (tgt_pvalid),
    .tgt_pready_o (tgt_pready)
  );

  ssr_cfg_unit #(
    .NumSsrs    (NumSsrs),
    .NumCfgRegs (NumCfgRegs)
  ) i_ssr_cfg_unit (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (acc_req_i),
    .qvalid_i (ssr_qvalid),
    .qready_o (ssr_qready),
    .rsp_o    (ssr_rsp),
    .pvalid_o (ssr_pvalid),
    .pready_i (ssr_pready)
  );

endmodule

// File: tb/offload_hub_tb.sv
/*
 * Offload hub testbench. External FPU and multiply/divide models,
 * directed and random stimulus, and assertion based checking.
 */

`timescale 1ns/1ns

// External accelerator with a random accept delay and a held response
module accel_model #(
  parameter logic [1:0] TgtNum = 2'd0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  qvalid_i,
  output logic                  qready_o,
  input  offload_pkg::acc_req_t req_i,
  output offload_pkg::acc_rsp_t rsp_o,
  output logic                  pvalid_o,
  input  logic                  pready_i
);

  import offload_pkg::*;

  logic        q_hs;
  logic        p_hs;
  logic        q_seen;
  acc_req_t    req_s;
  int unsigned delay;

  initial begin
    qready_o = 1'b0;
    pvalid_o = 1'b0;
    rsp_o    = '0;
    delay    = 0;
  end

  // Sample mid-cycle and update just after the rising edge
  always @(negedge clk_i) begin
    q_hs   = qvalid_i && qready_o;
    p_hs   = pvalid_o && pready_i;
    q_seen = qvalid_i;
    req_s  = req_i;
    @(posedge clk_i);
    #1;
    if (rst_ni) begin
      qready_o = 1'b0;
      pvalid_o = 1'b0;
      delay    = $urandom % 4;
    end else begin
      if (p_hs)
        pvalid_o = 1'b0;
      if (q_hs) begin
        qready_o    = 1'b0;
        pvalid_o    = 1'b1;
        rsp_o.id    = req_s.id;
        rsp_o.error = 1'b0;
        rsp_o.data  = req_s.data_arga + 32'(TgtNum);
        delay       = $urandom % 4;
      end else if (q_seen && !pvalid_o) begin
        if (delay == 0)
          qready_o = 1'b1;
        else
          delay--;
      end
    end
  end

endmodule

module offload_hub_tb;

  import offload_pkg::*;

  localparam int unsigned NumSsrs    = 2;
  localparam int unsigned NumCfgRegs = 4;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  acc_req_t acc_req_i;
  logic     acc_qvalid_i, acc_qready_o, acc_pvalid_o, acc_pready_i;
  acc_rsp_t acc_rsp_o, fpu_rsp_i, shared_rsp_i;
  logic     fpu_qvalid_o, fpu_qready_i, fpu_pvalid_i, fpu_pready_o;
  logic     shared_qvalid_o, shared_qready_i, shared_pvalid_i, shared_pready_o;

  // Scoreboard state
  acc_rsp_t              exp_q[$];
  logic [DataWidth-1:0]  cfg_model [NumSsrs][NumCfgRegs];
  logic [NumTargets-1:0] owed [NumTargets];
  logic                  rsp_ok, fair_ok, rsp_hs, aborted;
  acc_rsp_t              got_rsp, want_rsp;
  int                    err_cnt, err_mark, tests_run;
  logic [4:0]            next_id;

  always #4 clk_i = ~clk_i;

  offload_hub #(
    .NumSsrs    (NumSsrs),
    .NumCfgRegs (NumCfgRegs)
  ) UUT (
    .clk_i, .rst_ni, .acc_req_i, .acc_qvalid_i, .acc_qready_o, .acc_rsp_o,
    .acc_pvalid_o, .acc_pready_i, .fpu_qvalid_o, .fpu_qready_i, .fpu_rsp_i,
    .fpu_pvalid_i, .fpu_pready_o, .shared_qvalid_o, .shared_qready_i,
    .shared_rsp_i, .shared_pvalid_i, .shared_pready_o
  );

  accel_model #(.TgtNum(2'd0)) fpu_model (
    .clk_i, .rst_ni, .qvalid_i(fpu_qvalid_o), .qready_o(fpu_qready_i), .req_i(acc_req_i),
    .rsp_o(fpu_rsp_i), .pvalid_o(fpu_pvalid_i), .pready_i(fpu_pready_o)
  );

  accel_model #(.TgtNum(2'd1)) shared_model (
    .clk_i, .rst_ni, .qvalid_i(shared_qvalid_o), .qready_o(shared_qready_i),
    .req_i(acc_req_i), .rsp_o(shared_rsp_i), .pvalid_o(shared_pvalid_i),
    .pready_i(shared_pready_o)
  );

  assign rsp_hs = acc_pvalid_o && acc_pready_i;

  // ---------------------------------------------------------------------
  // Scoreboard sampled mid-cycle where everything is stable
  // ---------------------------------------------------------------------
  always @(negedge clk_i) begin : scoreboard
    logic [NumTargets-1:0] pv;
    logic [NumTargets-1:0] gnt;
    logic [2:0]            f3;
    logic [11:0]           a;
    logic                  wr;
    logic                  inr;
    int                    idx;
    acc_rsp_t              want;
    rsp_ok  = 1'b1;
    fair_ok = 1'b1;
    if (rst_ni) begin
      exp_q.delete();
      foreach (owed[t])
        owed[t] = '0;
      foreach (cfg_model[d, r])
        cfg_model[d][r] = '0;
    end else begin
      pv  = {UUT.ssr_pvalid, shared_pvalid_i, fpu_pvalid_i};
      gnt = pv & {UUT.ssr_pready, shared_pready_o, fpu_pready_o};
      if (rsp_hs) begin
        idx = -1;
        foreach (exp_q[i]) begin
          if (idx < 0 && exp_q[i] == acc_rsp_o)
            idx = i;
        end
        got_rsp  = acc_rsp_o;
        want_rsp = (exp_q.size() > 0) ? exp_q[0] : '0;
        if (idx < 0)
          rsp_ok = 1'b0;
        else
          exp_q.delete(idx);
        // Targets that waited at a grant must be served before it repeats
        for (int t = 0; t < NumTargets; t++) begin
          if (gnt[t]) begin
            if (owed[t] != '0)
              fair_ok = 1'b0;
            owed[t] = pv & ~gnt;
          end else begin
            owed[t] = owed[t] & ~gnt;
          end
        end
      end
      if (acc_qvalid_i && acc_qready_o) begin
        want.id    = acc_req_i.id;
        want.error = 1'b0;
        want.data  = acc_req_i.data_arga + 32'(acc_req_i.addr);
        if (acc_req_i.addr == 2'd2) begin
          f3  = acc_req_i.data_op[14:12];
          wr  = (f3 == F3ScfgWi) || (f3 == F3ScfgW);
          a   = (f3 == F3ScfgRi || f3 == F3ScfgWi) ? acc_req_i.data_op[31:20]
                                                   : acc_req_i.data_argb[11:0];
          inr = (a[4:0] < NumSsrs) && (a[11:5] < NumCfgRegs);
          want.data = inr ? cfg_model[a[4:0]][a[11:5]] : '0;
          if (wr)
            want.id = '0;
          if (wr && inr)
            cfg_model[a[4:0]][a[11:5]] = acc_req_i.data_arga;
        end
        exp_q.push_back(want);
      end
    end
  end

  // ---------------------------------------------------------------------
  // Checks
  // ---------------------------------------------------------------------
  assert property (@(posedge clk_i) $fell(rst_ni) |->
    !acc_pvalid_o && !fpu_qvalid_o && !shared_qvalid_o)
    else log_error($sformatf(
      "Mismatch acc_pvalid_o/fpu_qvalid_o/shared_qvalid_o: got %h %h %h, expected 0 0 0",
      acc_pvalid_o, fpu_qvalid_o, shared_qvalid_o));

  assert property (@(posedge clk_i) disable iff (rst_ni) acc_qvalid_i |->
    (fpu_qvalid_o == (acc_req_i.addr == 2'd0)) &&
    (shared_qvalid_o == (acc_req_i.addr == 2'd1)))
    else log_error($sformatf("Mismatch fpu_qvalid_o/shared_qvalid_o: addr %h, got %h %h",
                             acc_req_i.addr, fpu_qvalid_o, shared_qvalid_o));

  assert property (@(posedge clk_i) disable iff (rst_ni)
    (acc_qvalid_i && acc_req_i.addr != 2'd2) |->
    (acc_qready_o == ((acc_req_i.addr == 2'd0) ? fpu_qready_i : shared_qready_i)))
    else log_error($sformatf("Mismatch acc_qready_o: got %h, fpu_qready_i %h, shared_qready_i %h",
                             acc_qready_o, fpu_qready_i, shared_qready_i));

  assert property (@(posedge clk_i) disable iff (rst_ni) rsp_hs |-> rsp_ok)
    else log_error($sformatf("Mismatch acc_rsp_o: got %h, expected %h", got_rsp, want_rsp));

  // Configuration response one cycle after the request when uncontested
  assert property (@(posedge clk_i) disable iff (rst_ni)
    (acc_qvalid_i && acc_qready_o && acc_req_i.addr == 2'd2 && acc_pready_i &&
     !fpu_pvalid_i && !shared_pvalid_i) |=> acc_pvalid_o)
    else log_error("Configuration response did not arrive one cycle after its request");

  assert property (@(posedge clk_i) disable iff (rst_ni) rsp_hs |-> fair_ok)
    else log_error("Arbiter granted a target twice while another response was waiting");

  assert property (@(posedge clk_i) disable iff (rst_ni)
    (acc_pvalid_o && !acc_pready_i) |=> (acc_pvalid_o && $stable(acc_rsp_o)))
    else log_error("Response was dropped or changed while the core stalled it");

  // ---------------------------------------------------------------------
  // Stimulus helpers
  // ---------------------------------------------------------------------
  task automatic log_error(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic abort(input string msg);
    log_error(msg);
    aborted = 1'b1;
  endtask

  task automatic issue(input acc_req_t req);
    int   n;
    logic hs;
    if (aborted)
      return;
    acc_req_i    = req;
    acc_qvalid_i = 1'b1;
    hs = 1'b0;
    n  = 0;
    while (!hs && !aborted) begin
      @(negedge clk_i);
      hs = acc_qready_o;
      @(posedge clk_i);
      #1;
      n++;
      if (!hs && n > 100)
        abort($sformatf("Timeout: request id %0d to target %0d was never accepted",
                        req.id, req.addr));
    end
    acc_qvalid_i = 1'b0;
  endtask

  task automatic ext_access(input logic [1:0] tgt);
    acc_req_t req;
    next_id       = (next_id == 5'd31) ? 5'd1 : next_id + 5'd1;
    req.id        = next_id;
    req.addr      = tgt;
    req.data_op   = $urandom;
    req.data_arga = $urandom;
    req.data_argb = $urandom;
    issue(req);
  endtask

  // Immediate form puts junk in argb and register form junk in the immediate
  task automatic cfg_access(input logic wr, input logic imm, input logic [11:0] a,
                            input logic [31:0] wdata);
    acc_req_t   req;
    logic [2:0] f3;
    f3 = imm ? (wr ? F3ScfgWi : F3ScfgRi) : (wr ? F3ScfgW : F3ScfgR);
    next_id       = (next_id == 5'd31) ? 5'd1 : next_id + 5'd1;
    req.id        = next_id;
    req.addr      = 2'd2;
    req.data_op   = {imm ? a : 12'($urandom), 5'd3, f3, 5'd7, SsrCfgOpcode};
    req.data_arga = wdata;
    req.data_argb = imm ? $urandom : {20'($urandom), a};
    issue(req);
  endtask

  task automatic wait_all_pending();
    int n;
    n = 0;
    while (!aborted && !(fpu_pvalid_i && shared_pvalid_i && UUT.ssr_pvalid)) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 20)
        abort("Timeout: responses from all three targets never became pending together");
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (!aborted && exp_q.size() != 0) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 100)
        abort($sformatf("Timeout: %0d responses never returned", exp_q.size()));
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s: %s, %0d errors", name, (err_cnt == err_mark) ? "ok" : "FAILED",
             err_cnt - err_mark);
    err_mark = err_cnt;
    tests_run++;
  endtask

  // ---------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------
  initial begin
    logic bp_done;
    void'($urandom(79));
    rst_ni       = 1'b1;
    acc_req_i    = '0;
    acc_qvalid_i = 1'b0;
    acc_pready_i = 1'b1;
    aborted      = 1'b0;
    err_cnt      = 0;
    err_mark     = 0;
    tests_run    = 0;
    next_id      = 5'd0;
    bp_done      = 1'b0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    end_test("reset state");

    for (int i = 0; i < 8; i++)
      ext_access(2'(i % 2));
    drain();
    end_test("routing");

    for (int d = 0; d < NumSsrs; d++) begin
      for (int r = 0; r < NumCfgRegs; r++) begin
        cfg_access(1'b1, 1'((d + r) % 2), {7'(r), 5'(d)}, $urandom);
        cfg_access(1'b1, 1'((d + r + 1) % 2), {7'(r), 5'(d)}, $urandom);
        cfg_access(1'b0, 1'((d + r + 1) % 2), {7'(r), 5'(d)}, '0);
      end
    end
    drain();
    end_test("config write and read");

    // Out-of-range writes followed by reads of them and of the whole bank
    cfg_access(1'b1, 1'b1, {7'd0, 5'(NumSsrs)}, 32'hdead_beef);
    cfg_access(1'b1, 1'b0, {7'(NumCfgRegs), 5'd1}, 32'hcafe_f00d);
    cfg_access(1'b0, 1'b0, {7'd0, 5'(NumSsrs)}, '0);
    cfg_access(1'b0, 1'b1, {7'(NumCfgRegs), 5'd1}, '0);
    foreach (cfg_model[d, r])
      cfg_access(1'b0, 1'b0, {7'(r), 5'(d)}, '0);
    drain();
    end_test("out-of-range addresses");

    for (int k = 0; k < 3; k++) begin
      acc_pready_i = 1'b0;
      ext_access(2'd0);
      ext_access(2'd1);
      cfg_access(1'b0, 1'b1, {7'(k), 5'd0}, '0);
      wait_all_pending();
      acc_pready_i = 1'b1;
      // Refill the configuration buffer while the others still wait
      cfg_access(1'b0, 1'b0, {7'(k), 5'd1}, '0);
      drain();
    end
    end_test("arbitration");

    fork
      begin
        for (int i = 0; i < 24; i++) begin
          if ($urandom % 3 == 2)
            cfg_access(1'($urandom), 1'($urandom), {7'($urandom % 5), 5'($urandom % 3)},
                       $urandom);
          else
            ext_access(2'($urandom % 2));
        end
        bp_done = 1'b1;
      end
      // Random stretches of back-pressure
      while (!bp_done) begin
        acc_pready_i = 1'($urandom);
        repeat ($urandom % 4 + 1) @(posedge clk_i);
        #1;
      end
    join
    acc_pready_i = 1'b1;
    drain();
    end_test("back-pressure");

    $display("Summary: %0d tests run, %0d errors", tests_run, err_cnt);
    if (err_cnt == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: sources.f
hdl/offload_pkg.sv
hdl/ssr_cfg_unit.sv
hdl/offload_xbar.sv
hdl/offload_hub.sv
tb/offload_hub_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the offload hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module offload_hub_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Voffload_hub_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

echo "$out" | grep -q "All tests passed" || exit 1
exit 0
